//--- mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Data path word width
`define MIPS_DATA_W 32

// Byte address width
`define MIPS_ADDR_W 32

// Data RAM depth in words
`define MIPS_DMEM_WORDS 256

// Register number width
`define MIPS_REG_W 5

`endif

//--- mips_pkg.sv
`default_nettype none

`include "mips_settings.svh"

package mips_pkg;

    typedef logic [`MIPS_DATA_W-1:0]   word_t;
    typedef logic [`MIPS_REG_W-1:0]    reg_addr_t;
    typedef logic [`MIPS_DATA_W/8-1:0] byte_en_t;

    // Operation carried down the pipe, memory ops included
    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LB,
        ALU_LBU,
        ALU_LH,
        ALU_LHU,
        ALU_LW,
        ALU_SB,
        ALU_SH,
        ALU_SW
    } alu_op_t;

    // Only the address errors are modelled
    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_ADEL,
        EXC_ADES
    } exc_t;

endpackage

`default_nettype wire

//--- ex_mem_if.sv
`default_nettype none

interface ex_mem_if;

    mips_pkg::word_t     pc;
    mips_pkg::alu_op_t   aluop;
    mips_pkg::word_t     alures;
    mips_pkg::byte_en_t  m_wen;
    mips_pkg::word_t     m_wdata;
    logic                wreg;
    mips_pkg::reg_addr_t wraddr;
    mips_pkg::exc_t      excp;
    logic                null_item;
    logic                issue;

    modport source (
        output pc,
        output aluop,
        output alures,
        output m_wen,
        output m_wdata,
        output wreg,
        output wraddr,
        output excp,
        output null_item,
        output issue
    );

    modport sink (
        input pc,
        input aluop,
        input alures,
        input m_wen,
        input m_wdata,
        input wreg,
        input wraddr,
        input excp,
        input null_item,
        input issue
    );

endinterface

`default_nettype wire

//--- ex_stage.sv
`default_nettype none

module ex_stage (
    input  mips_pkg::word_t     in_pc,
    input  mips_pkg::alu_op_t   in_aluop,
    input  mips_pkg::word_t     src_a,
    input  mips_pkg::word_t     src_b,
    input  mips_pkg::word_t     store_data,
    input  mips_pkg::reg_addr_t in_wraddr,
    input  logic                in_valid,
    ex_mem_if.source            out
);

    mips_pkg::word_t    ea;
    mips_pkg::word_t    alu_res;
    mips_pkg::byte_en_t wen_raw;
    logic               is_load;
    logic               is_store;
    logic               is_alu;
    logic               addr_err;

    assign ea = src_a + src_b;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_alu   = 1'b0;
        addr_err = 1'b0;
        alu_res  = ea;
        wen_raw  = '0;
        case (in_aluop)
            mips_pkg::ALU_ADD: begin is_alu = 1'b1; alu_res = ea; end
            mips_pkg::ALU_SUB: begin is_alu = 1'b1; alu_res = src_a - src_b; end
            mips_pkg::ALU_AND: begin is_alu = 1'b1; alu_res = src_a & src_b; end
            mips_pkg::ALU_OR:  begin is_alu = 1'b1; alu_res = src_a | src_b; end
            mips_pkg::ALU_XOR: begin is_alu = 1'b1; alu_res = src_a ^ src_b; end
            mips_pkg::ALU_SLT: begin
                is_alu  = 1'b1;
                alu_res = {31'd0, $signed(src_a) < $signed(src_b)};
            end
            mips_pkg::ALU_LB, mips_pkg::ALU_LBU: is_load = 1'b1;
            mips_pkg::ALU_LH, mips_pkg::ALU_LHU: begin
                is_load  = 1'b1;
                addr_err = ea[0];
            end
            mips_pkg::ALU_LW: begin
                is_load  = 1'b1;
                addr_err = ea[1:0] != 2'b00;
            end
            mips_pkg::ALU_SB: begin
                is_store = 1'b1;
                wen_raw  = 4'b0001 << ea[1:0];
            end
            mips_pkg::ALU_SH: begin
                is_store = 1'b1;
                addr_err = ea[0];
                wen_raw  = ea[1] ? 4'b1100 : 4'b0011;
            end
            mips_pkg::ALU_SW: begin
                is_store = 1'b1;
                addr_err = ea[1:0] != 2'b00;
                wen_raw  = 4'b1111;
            end
            default: alu_res = '0;
        endcase
    end

    // Store data replicated so every lane sees its bytes
    always_comb begin
        case (in_aluop)
            mips_pkg::ALU_SB: out.m_wdata = {4{store_data[7:0]}};
            mips_pkg::ALU_SH: out.m_wdata = {2{store_data[15:0]}};
            default:          out.m_wdata = store_data;
        endcase
    end

    assign out.pc        = in_pc;
    assign out.aluop     = in_aluop;
    assign out.alures    = alu_res;
    assign out.m_wen     = (in_valid && !addr_err) ? wen_raw : '0;
    assign out.wreg      = in_valid && (is_alu || is_load) && !addr_err && (in_wraddr != '0);
    assign out.wraddr    = in_wraddr;
    assign out.excp      = !(in_valid && addr_err) ? mips_pkg::EXC_NONE :
                           is_store ? mips_pkg::EXC_ADES : mips_pkg::EXC_ADEL;
    assign out.null_item = !in_valid;
    // Issue is generated by the EX/MEM register, not here
    assign out.issue     = 1'b0;

endmodule

`default_nettype wire

//--- ex_mem_reg.sv
`default_nettype none

module ex_mem_reg (
    input  logic       clk,
    input  logic       rst,
    input  logic       stall,
    input  logic       flush,
    ex_mem_if.sink     ex_side,
    ex_mem_if.source   mem_side
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_side.pc        <= '0;
            mem_side.aluop     <= mips_pkg::ALU_NOP;
            mem_side.alures    <= '0;
            mem_side.m_wen     <= '0;
            mem_side.m_wdata   <= '0;
            mem_side.wreg      <= 1'b0;
            mem_side.wraddr    <= '0;
            mem_side.excp      <= mips_pkg::EXC_NONE;
            mem_side.null_item <= 1'b1;
            mem_side.issue     <= 1'b0;
        end else if (flush) begin
            // Flush wins over stall and inserts a bubble
            mem_side.pc        <= '0;
            mem_side.aluop     <= mips_pkg::ALU_NOP;
            mem_side.alures    <= '0;
            mem_side.m_wen     <= '0;
            mem_side.m_wdata   <= '0;
            mem_side.wreg      <= 1'b0;
            mem_side.wraddr    <= '0;
            mem_side.excp      <= mips_pkg::EXC_NONE;
            mem_side.null_item <= 1'b1;
            mem_side.issue     <= 1'b0;
        end else if (stall) begin
            // Contents held, but the item must not reach memory twice
            mem_side.issue     <= 1'b0;
        end else begin
            mem_side.pc        <= ex_side.pc;
            mem_side.aluop     <= ex_side.aluop;
            mem_side.alures    <= ex_side.alures;
            mem_side.m_wen     <= ex_side.m_wen;
            mem_side.m_wdata   <= ex_side.m_wdata;
            mem_side.wreg      <= ex_side.wreg;
            mem_side.wraddr    <= ex_side.wraddr;
            mem_side.excp      <= ex_side.excp;
            mem_side.null_item <= ex_side.null_item;
            mem_side.issue     <= !ex_side.null_item;
        end
    end

endmodule

`default_nettype wire

//--- mem_stage.sv
`default_nettype none

`include "mips_settings.svh"

module mem_stage (
    input  logic                clk,
    input  logic                rst,
    ex_mem_if.sink              in,
    output logic                wb_valid,
    output mips_pkg::word_t     wb_pc,
    output mips_pkg::reg_addr_t wb_wraddr,
    output mips_pkg::word_t     wb_data,
    output logic                wb_wen,
    output mips_pkg::exc_t      wb_excp
);

    localparam int IDX_W = $clog2(`MIPS_DMEM_WORDS);

    mips_pkg::word_t        dmem [`MIPS_DMEM_WORDS];
    logic [`MIPS_ADDR_W-1:0] addr;
    logic [IDX_W-1:0]        idx;
    logic                    live;
    mips_pkg::word_t         rd_word;
    logic [7:0]              rd_byte;
    logic [15:0]             rd_half;
    mips_pkg::word_t         load_data;
    logic                    is_load;

    assign addr = in.alures;
    // Word index above the byte offset, wraps modulo the depth
    assign idx  = addr[2 +: IDX_W];
    assign live = in.issue && !in.null_item;

    assign rd_word = dmem[idx];
    assign rd_byte = rd_word[8*addr[1:0] +: 8];
    assign rd_half = addr[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        is_load   = 1'b1;
        load_data = rd_word;
        case (in.aluop)
            mips_pkg::ALU_LB:  load_data = {{24{rd_byte[7]}}, rd_byte};
            mips_pkg::ALU_LBU: load_data = {24'd0, rd_byte};
            mips_pkg::ALU_LH:  load_data = {{16{rd_half[15]}}, rd_half};
            mips_pkg::ALU_LHU: load_data = {16'd0, rd_half};
            mips_pkg::ALU_LW:  load_data = rd_word;
            default:           is_load = 1'b0;
        endcase
    end

    // Byte-lane writes; a misaligned store arrives with no enables
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MIPS_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (live) begin
            for (int b = 0; b < 4; b++) begin
                if (in.m_wen[b]) begin
                    dmem[idx][8*b +: 8] <= in.m_wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_wen   <= 1'b0;
            wb_excp  <= mips_pkg::EXC_NONE;
        end else begin
            wb_valid <= live;
            wb_wen   <= live && in.wreg && (in.excp == mips_pkg::EXC_NONE);
            wb_excp  <= live ? in.excp : mips_pkg::EXC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (live) begin
            wb_pc     <= in.pc;
            wb_wraddr <= in.wraddr;
            wb_data   <= is_load ? load_data : in.alures;
        end
    end

endmodule

`default_nettype wire

//--- mips_exmem_top.sv
`default_nettype none

module mips_exmem_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                flush,
    input  logic                in_valid,
    input  mips_pkg::word_t     in_pc,
    input  mips_pkg::alu_op_t   in_aluop,
    input  mips_pkg::word_t     src_a,
    input  mips_pkg::word_t     src_b,
    input  mips_pkg::word_t     store_data,
    input  mips_pkg::reg_addr_t in_wraddr,
    output logic                wb_valid,
    output mips_pkg::word_t     wb_pc,
    output mips_pkg::reg_addr_t wb_wraddr,
    output mips_pkg::word_t     wb_data,
    output logic                wb_wen,
    output mips_pkg::exc_t      wb_excp
);

    // Execute outputs, then the registered item seen by memory
    ex_mem_if ex_bus ();
    ex_mem_if mem_bus ();

    ex_stage ex_stage_inst (
        .in_pc      (in_pc),
        .in_aluop   (in_aluop),
        .src_a      (src_a),
        .src_b      (src_b),
        .store_data (store_data),
        .in_wraddr  (in_wraddr),
        .in_valid   (in_valid),
        .out        (ex_bus.source)
    );

    ex_mem_reg ex_mem_reg_inst (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .flush    (flush),
        .ex_side  (ex_bus.sink),
        .mem_side (mem_bus.source)
    );

    mem_stage mem_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .in        (mem_bus.sink),
        .wb_valid  (wb_valid),
        .wb_pc     (wb_pc),
        .wb_wraddr (wb_wraddr),
        .wb_data   (wb_data),
        .wb_wen    (wb_wen),
        .wb_excp   (wb_excp)
    );

endmodule

`default_nettype wire

//--- mips_exmem_assert.sv
`default_nettype none

module mips_exmem_assert (
    input logic           clk,
    input logic           rst,
    input logic           flush,
    input logic           wb_valid,
    input logic           wb_wen,
    input mips_pkg::exc_t wb_excp
);
    timeunit 1ns;
    timeprecision 1ps;

    // A flushed slot leaves a bubble that reaches writeback two edges later
    no_wb_after_flush: assert property (
        @(posedge clk) disable iff (rst) $past(flush, 2) |-> !wb_valid
    ) else $error("wb_valid set for a slot that was flushed");

    wen_needs_valid: assert property (
        @(posedge clk) disable iff (rst)
        wb_wen |-> (wb_valid && wb_excp == mips_pkg::EXC_NONE)
    ) else $error("wb_wen set without a valid, exception-free writeback");

    quiet_in_reset: assert property (
        @(posedge clk) rst |-> !wb_valid
    ) else $error("wb_valid set while reset is active");

endmodule

bind mips_exmem_top mips_exmem_assert mips_exmem_assert_inst (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .wb_valid (wb_valid),
    .wb_wen   (wb_wen),
    .wb_excp  (wb_excp)
);

`default_nettype wire

//--- tb_mips_exmem.sv
`default_nettype none

`include "mips_settings.svh"

module tb_mips_exmem;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DRAIN_TIMEOUT = 50;

    typedef struct packed {
        mips_pkg::alu_op_t   op;
        mips_pkg::word_t     a;
        mips_pkg::word_t     b;
        mips_pkg::word_t     sd;
        mips_pkg::reg_addr_t wr;
        logic                valid;
        logic                stall;
        logic                flush;
    } row_t;

    typedef struct packed {
        mips_pkg::word_t     pc;
        mips_pkg::word_t     data;
        mips_pkg::reg_addr_t wraddr;
        logic                wen;
        mips_pkg::exc_t      excp;
        logic                data_ok;
    } exp_t;

    logic                clk;
    logic                rst;
    logic                stall;
    logic                flush;
    logic                in_valid;
    mips_pkg::word_t     in_pc;
    mips_pkg::alu_op_t   in_aluop;
    mips_pkg::word_t     src_a;
    mips_pkg::word_t     src_b;
    mips_pkg::word_t     store_data;
    mips_pkg::reg_addr_t in_wraddr;
    logic                wb_valid;
    mips_pkg::word_t     wb_pc;
    mips_pkg::reg_addr_t wb_wraddr;
    mips_pkg::word_t     wb_data;
    logic                wb_wen;
    mips_pkg::exc_t      wb_excp;

    row_t            rows[$];
    string           names[$];
    exp_t            exp_q[$];
    string           exp_name[$];
    mips_pkg::word_t ref_mem [`MIPS_DMEM_WORDS];
    exp_t            cur_exp;
    string           cur_name;
    int              errors = 0;
    int              n_wb = 0;
    int              seed = 16746;

    mips_exmem_top mips_exmem_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_row(input string name, input mips_pkg::alu_op_t op,
                           input mips_pkg::word_t a, input mips_pkg::word_t b,
                           input mips_pkg::word_t sd, input mips_pkg::reg_addr_t wr,
                           input logic valid, input logic stl, input logic fl);
        row_t r;
        r = '{op: op, a: a, b: b, sd: sd, wr: wr, valid: valid, stall: stl, flush: fl};
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic add_random_rows(input int count);
        row_t r;
        int   sel;
        for (int k = 0; k < count; k++) begin
            sel     = int'($unsigned($random(seed)) % 6);
            // ADD through SLT are consecutive in the operation enum
            r.op    = mips_pkg::alu_op_t'(4'(sel + 1));
            r.a     = $random(seed);
            r.b     = $random(seed);
            r.sd    = '0;
            r.wr    = mips_pkg::reg_addr_t'($random(seed));
            r.valid = 1'b1;
            r.stall = 1'b0;
            r.flush = 1'b0;
            rows.push_back(r);
            names.push_back($sformatf("rand_%0d", k));
        end
    endtask

    // Expected writeback per instruction rule with the memory model updated in order
    task automatic predict(input row_t r, input mips_pkg::word_t pc, input string name);
        exp_t            e;
        mips_pkg::word_t ea;
        mips_pkg::word_t w;
        logic [7:0]      b8;
        logic [15:0]     h16;
        int              idx;
        int              lane;
        int              hsel;
        logic            mis;
        logic            is_st;
        ea    = r.a + r.b;
        idx   = int'((ea >> 2) % `MIPS_DMEM_WORDS);
        lane  = int'(ea[1:0]);
        hsel  = int'(ea[1]);
        w     = ref_mem[idx];
        b8    = w[8*lane +: 8];
        h16   = w[16*hsel +: 16];
        is_st = r.op inside {mips_pkg::ALU_SB, mips_pkg::ALU_SH, mips_pkg::ALU_SW};
        mis   = (r.op inside {mips_pkg::ALU_LH, mips_pkg::ALU_LHU, mips_pkg::ALU_SH} && ea[0])
             || (r.op inside {mips_pkg::ALU_LW, mips_pkg::ALU_SW} && ea[1:0] != 2'b00);
        e.pc      = pc;
        e.wraddr  = r.wr;
        e.data_ok = !mis;
        e.wen     = !mis && !is_st && r.wr != '0;
        e.excp    = !mis ? mips_pkg::EXC_NONE : is_st ? mips_pkg::EXC_ADES : mips_pkg::EXC_ADEL;
        e.data    = ea;
        case (r.op)
            mips_pkg::ALU_SUB: e.data = r.a - r.b;
            mips_pkg::ALU_AND: e.data = r.a & r.b;
            mips_pkg::ALU_OR:  e.data = r.a | r.b;
            mips_pkg::ALU_XOR: e.data = r.a ^ r.b;
            mips_pkg::ALU_SLT: begin
                // With differing signs the negative operand is the smaller one
                e.data = (r.a[31] != r.b[31]) ? {31'd0, r.a[31]} : {31'd0, r.a < r.b};
            end
            mips_pkg::ALU_LB:  e.data = 32'($signed(b8));
            mips_pkg::ALU_LBU: e.data = 32'(b8);
            mips_pkg::ALU_LH:  e.data = 32'($signed(h16));
            mips_pkg::ALU_LHU: e.data = 32'(h16);
            mips_pkg::ALU_LW:  e.data = w;
            mips_pkg::ALU_SB:  ref_mem[idx][8*lane +: 8] = r.sd[7:0];
            mips_pkg::ALU_SH:  if (!mis) ref_mem[idx][16*hsel +: 16] = r.sd[15:0];
            mips_pkg::ALU_SW:  if (!mis) ref_mem[idx] = r.sd;
            default:           e.data = ea;
        endcase
        exp_q.push_back(e);
        exp_name.push_back(name);
    endtask

    task automatic apply_row(input int i);
        row_t            r;
        mips_pkg::word_t pc;
        r           = rows[i];
        pc          = 32'h0040_0000 + i * 4;
        in_pc      <= pc;
        in_aluop   <= r.op;
        src_a      <= r.a;
        src_b      <= r.b;
        store_data <= r.sd;
        in_wraddr  <= r.wr;
        in_valid   <= r.valid;
        stall      <= r.stall;
        flush      <= r.flush;
        if (r.valid && !r.stall && !r.flush) begin
            predict(r, pc, names[i]);
        end
    endtask

    task automatic check_value(input string tname, input string field,
                               input mips_pkg::word_t exp, input mips_pkg::word_t act);
        assert (exp === act) else begin
            $display("[ERROR] %s %s: expected %h, actual %h", tname, field, exp, act);
            errors++;
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst) begin
            assert (wb_valid !== 1'b1) else begin
                $display("wb_valid was high while reset was active");
                errors++;
            end
        end else if (wb_valid) begin
            n_wb++;
            assert (exp_q.size() != 0) else begin
                $display("Unexpected writeback for pc %h with nothing pending", wb_pc);
                errors++;
            end
            if (exp_q.size() != 0) begin
                cur_exp  = exp_q.pop_front();
                cur_name = exp_name.pop_front();
                check_value(cur_name, "wb_pc", cur_exp.pc, wb_pc);
                check_value(cur_name, "wb_wraddr", {27'd0, cur_exp.wraddr}, {27'd0, wb_wraddr});
                check_value(cur_name, "wb_wen", {31'd0, cur_exp.wen}, {31'd0, wb_wen});
                check_value(cur_name, "wb_excp", {30'd0, cur_exp.excp}, {30'd0, wb_excp});
                if (cur_exp.data_ok) begin
                    check_value(cur_name, "wb_data", cur_exp.data, wb_data);
                end
            end
        end
    end

    initial begin
        int wait_cycles;
        rst        = 1'b1;
        stall      = 1'b0;
        flush      = 1'b0;
        in_valid   = 1'b0;
        in_pc      = '0;
        in_aluop   = mips_pkg::ALU_NOP;
        src_a      = '0;
        src_b      = '0;
        store_data = '0;
        in_wraddr  = '0;
        for (int k = 0; k < `MIPS_DMEM_WORDS; k++) begin
            ref_mem[k] = '0;
        end

        // name, op, a, b, store data, dest, valid, stall, flush
        add_row("zero_lw_0", mips_pkg::ALU_LW, 32'h0, 32'h0, 32'h0, 5'd1, 1, 0, 0);
        add_row("zero_lw_top", mips_pkg::ALU_LW, 32'h3FC, 32'h0, 32'h0, 5'd2, 1, 0, 0);
        add_row("zero_lbu_wrap", mips_pkg::ALU_LBU, 32'h1234_5000, 32'h7, 32'h0, 5'd3, 1, 0, 0);
        add_row("add", mips_pkg::ALU_ADD, 32'd5, 32'd7, 32'h0, 5'd4, 1, 0, 0);
        add_row("sub_neg", mips_pkg::ALU_SUB, 32'd3, 32'd10, 32'h0, 5'd5, 1, 0, 0);
        add_row("and", mips_pkg::ALU_AND, 32'hF0F0_1234, 32'h0FF0_FF00, 32'h0, 5'd6, 1, 0, 0);
        add_row("or", mips_pkg::ALU_OR, 32'hF000_0001, 32'h0000_1000, 32'h0, 5'd7, 1, 0, 0);
        add_row("xor", mips_pkg::ALU_XOR, 32'hAAAA_5555, 32'hFFFF_0000, 32'h0, 5'd8, 1, 0, 0);
        add_row("slt_neg", mips_pkg::ALU_SLT, 32'hFFFF_FFFF, 32'd1, 32'h0, 5'd9, 1, 0, 0);
        add_row("slt_pos", mips_pkg::ALU_SLT, 32'd1, 32'hFFFF_FFFF, 32'h0, 5'd10, 1, 0, 0);
        add_row("add_r0", mips_pkg::ALU_ADD, 32'd1, 32'd2, 32'h0, 5'd0, 1, 0, 0);
        add_row("sw", mips_pkg::ALU_SW, 32'h100, 32'h0, 32'h8899_AABB, 5'd0, 1, 0, 0);
        add_row("lw", mips_pkg::ALU_LW, 32'h100, 32'h0, 32'h0, 5'd11, 1, 0, 0);
        add_row("lw_wrap", mips_pkg::ALU_LW, 32'h1234_5000, 32'h100, 32'h0, 5'd26, 1, 0, 0);
        add_row("sb_lane1", mips_pkg::ALU_SB, 32'h104, 32'd1, 32'h0000_00F0, 5'd0, 1, 0, 0);
        add_row("sb_lane3", mips_pkg::ALU_SB, 32'h104, 32'd3, 32'h1234_567F, 5'd0, 1, 0, 0);
        add_row("sh_upper", mips_pkg::ALU_SH, 32'h108, 32'd2, 32'h0000_8001, 5'd0, 1, 0, 0);
        add_row("sh_lower", mips_pkg::ALU_SH, 32'h108, 32'd0, 32'h0000_7FFE, 5'd0, 1, 0, 0);
        add_row("lb_sign", mips_pkg::ALU_LB, 32'h105, 32'h0, 32'h0, 5'd12, 1, 0, 0);
        add_row("lbu", mips_pkg::ALU_LBU, 32'h105, 32'h0, 32'h0, 5'd13, 1, 0, 0);
        add_row("lb_pos", mips_pkg::ALU_LB, 32'h107, 32'h0, 32'h0, 5'd14, 1, 0, 0);
        add_row("lh_sign", mips_pkg::ALU_LH, 32'h10A, 32'h0, 32'h0, 5'd15, 1, 0, 0);
        add_row("lhu", mips_pkg::ALU_LHU, 32'h10A, 32'h0, 32'h0, 5'd16, 1, 0, 0);
        add_row("lh_lower", mips_pkg::ALU_LH, 32'h108, 32'h0, 32'h0, 5'd27, 1, 0, 0);
        add_row("lw_lanes", mips_pkg::ALU_LW, 32'h104, 32'h0, 32'h0, 5'd17, 1, 0, 0);
        add_row("sw_mis", mips_pkg::ALU_SW, 32'h10C, 32'd1, 32'hDEAD_BEEF, 5'd0, 1, 0, 0);
        add_row("sh_mis", mips_pkg::ALU_SH, 32'h10C, 32'd3, 32'h0000_BEEF, 5'd0, 1, 0, 0);
        add_row("lw_mis", mips_pkg::ALU_LW, 32'h101, 32'h0, 32'h0, 5'd18, 1, 0, 0);
        add_row("lh_mis", mips_pkg::ALU_LH, 32'h103, 32'h0, 32'h0, 5'd19, 1, 0, 0);
        add_row("lw_untouched", mips_pkg::ALU_LW, 32'h10C, 32'h0, 32'h0, 5'd20, 1, 0, 0);
        add_row("add_flushed", mips_pkg::ALU_ADD, 32'd9, 32'd9, 32'h0, 5'd21, 1, 0, 1);
        add_row("flush_over_stall", mips_pkg::ALU_ADD, 32'd8, 32'd8, 32'h0, 5'd22, 1, 1, 1);
        add_row("add_after_flush", mips_pkg::ALU_ADD, 32'd7, 32'd7, 32'h0, 5'd23, 1, 0, 0);
        add_row("sw_held", mips_pkg::ALU_SW, 32'h110, 32'h0, 32'h1122_3344, 5'd0, 1, 0, 0);
        add_row("sw_stall_1", mips_pkg::ALU_SW, 32'h110, 32'h0, 32'h1122_3344, 5'd0, 1, 1, 0);
        add_row("sw_stall_2", mips_pkg::ALU_SW, 32'h110, 32'h0, 32'h1122_3344, 5'd0, 1, 1, 0);
        add_row("lw_after_stall", mips_pkg::ALU_LW, 32'h110, 32'h0, 32'h0, 5'd24, 1, 0, 0);
        add_row("bubble", mips_pkg::ALU_ADD, 32'd1, 32'd1, 32'h0, 5'd25, 0, 0, 0);
        add_random_rows(16);

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            apply_row(i);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        stall    <= 1'b0;
        flush    <= 1'b0;

        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        assert (exp_q.size() == 0) else begin
            $display("Timed out with %0d expected writebacks never seen", exp_q.size());
            errors++;
        end
        // A stray writeback would show within this window
        repeat (3) @(posedge clk);

        $display("Run complete: %0d errors, %0d writebacks checked", errors, n_wb);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
mips_pkg.sv
ex_mem_if.sv
ex_stage.sv
ex_mem_reg.sv
mem_stage.sv
mips_exmem_top.sv
mips_exmem_assert.sv
tb_mips_exmem.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mips_exmem -f sources.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
